// ==== common/raster_cfg.svh ====
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// Every datapath word is fixed point Q16.16.
`define RASTER_FRAC_BITS 16

// Viewport size in pixels.
`define RASTER_VIEWPORT_W 16
`define RASTER_VIEWPORT_H 12

// Width of one pixel coordinate.
`define RASTER_COORD_BITS 8

// Quotient bits of the area reciprocal divider.
`define RASTER_DIV_BITS 32

`endif

// ==== common/raster_pkg.sv ====
`default_nettype none

`include "raster_cfg.svh"

package raster_pkg;

    //////////////////////////////
    // Types
    //////////////////////////////

    // Signed Q16.16 word.
    typedef logic signed [31:0] fixed_t;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vertex_t;

    typedef struct packed {
        vertex_t a;
        vertex_t b;
        vertex_t c;
    } triangle_t;

    typedef struct packed {
        logic [`RASTER_COORD_BITS-1:0] x;
        logic [`RASTER_COORD_BITS-1:0] y;
    } pixel_coord_t;

    //////////////////////////////
    // Fixed-point helpers
    //////////////////////////////

    // Full product, then back to Q16.16 (truncating).
    function automatic fixed_t fx_mul(fixed_t a, fixed_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return fixed_t'(prod >>> `RASTER_FRAC_BITS);
    endfunction

    function automatic fixed_t fx_from_int(int value);
        return fixed_t'(value <<< `RASTER_FRAC_BITS);
    endfunction

    // Edge function of the line p0 -> p1 evaluated at (qx, qy).
    // Screen y grows downward, so the y terms carry the opposite sign.
    // Positive on the inner side of a triangle wound the kept way.
    function automatic fixed_t edge_eq(vertex_t p0, vertex_t p1, fixed_t qx, fixed_t qy);
        fixed_t term_x;
        fixed_t term_y;
        fixed_t term_c;
        term_x = fx_mul(p0.y - p1.y, qx);
        term_y = fx_mul(p1.x - p0.x, qy);
        term_c = fx_mul(p0.x, p1.y) - fx_mul(p0.y, p1.x);
        return term_x + term_y + term_c;
    endfunction

    // Sum of weight times value over the three vertices.
    function automatic fixed_t bary_weight(
        fixed_t b0,
        fixed_t v0,
        fixed_t b1,
        fixed_t v1,
        fixed_t b2,
        fixed_t v2
    );
        fixed_t acc;
        acc = fx_mul(b0, v0) + fx_mul(b1, v1);
        return acc + fx_mul(b2, v2);
    endfunction

endpackage

`default_nettype wire

// ==== interpolator/triangle_interpolator.sv ====
`timescale 1ns/1ps
`default_nettype none

module triangle_interpolator (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  pix_valid,
    output logic                  pix_ready,
    input  raster_pkg::pixel_coord_t pix_coord,
    input  logic                  pix_last,
    input  raster_pkg::triangle_t pix_tri,
    input  raster_pkg::fixed_t    pix_area_inv,
    output logic                  out_valid,
    input  logic                  out_ready,
    output raster_pkg::pixel_coord_t out_coord,
    output logic                  out_covered,
    output raster_pkg::fixed_t    out_depth,
    output logic [11:0]           out_color,
    output logic                  out_last
);
    import raster_pkg::*;

    // The whole pipe freezes while the output is held.
    logic stall;
    assign stall = !out_ready;
    assign pix_ready = out_ready;

    logic valid_1_r, valid_2_r, valid_3_r, valid_4_r;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_1_r <= 1'b0;
            valid_2_r <= 1'b0;
            valid_3_r <= 1'b0;
            valid_4_r <= 1'b0;
        end else if (!stall) begin
            valid_1_r <= pix_valid;
            valid_2_r <= valid_1_r;
            valid_3_r <= valid_2_r;
            valid_4_r <= valid_3_r;
        end
    end

    //////////////////////////////
    // Stage 1 edge functions
    //////////////////////////////

    triangle_t tri_1_r;
    fixed_t area_inv_1_r;
    pixel_coord_t coord_1_r;
    logic last_1_r;

    // Triangle is re-latched with every pixel so it follows the sweep.
    always_ff @(posedge clk) begin
        if (!stall && pix_valid) begin
            tri_1_r <= pix_tri;
            area_inv_1_r <= pix_area_inv;
            coord_1_r <= pix_coord;
            last_1_r <= pix_last;
        end
    end

    fixed_t px_1_c, py_1_c;
    fixed_t f01_1_c, f12_1_c, f20_1_c;

    assign px_1_c = fx_from_int(int'(coord_1_r.x));
    assign py_1_c = fx_from_int(int'(coord_1_r.y));
    assign f01_1_c = edge_eq(tri_1_r.a, tri_1_r.b, px_1_c, py_1_c);
    assign f12_1_c = edge_eq(tri_1_r.b, tri_1_r.c, px_1_c, py_1_c);
    assign f20_1_c = edge_eq(tri_1_r.c, tri_1_r.a, px_1_c, py_1_c);

    //////////////////////////////
    // Stage 2 coverage and weights
    //////////////////////////////

    fixed_t az_2_r, bz_2_r, cz_2_r;
    fixed_t area_inv_2_r;
    fixed_t f01_2_r, f12_2_r, f20_2_r;
    pixel_coord_t coord_2_r;
    logic last_2_r;

    always_ff @(posedge clk) begin
        if (!stall) begin
            az_2_r <= tri_1_r.a.z;
            bz_2_r <= tri_1_r.b.z;
            cz_2_r <= tri_1_r.c.z;
            area_inv_2_r <= area_inv_1_r;
            f01_2_r <= f01_1_c;
            f12_2_r <= f12_1_c;
            f20_2_r <= f20_1_c;
            coord_2_r <= coord_1_r;
            last_2_r <= last_1_r;
        end
    end

    // Strictly inside all three edges with no fill rule on the boundary.
    logic covered_2_c;
    fixed_t b0_2_c, b1_2_c, b2_2_c;

    assign covered_2_c = (f01_2_r > 0) && (f12_2_r > 0) && (f20_2_r > 0);
    assign b0_2_c = fx_mul(f01_2_r, area_inv_2_r);
    assign b1_2_c = fx_mul(f12_2_r, area_inv_2_r);
    assign b2_2_c = fx_mul(f20_2_r, area_inv_2_r);

    //////////////////////////////
    // Stage 3 depth
    //////////////////////////////

    fixed_t az_3_r, bz_3_r, cz_3_r;
    fixed_t b0_3_r, b1_3_r, b2_3_r;
    pixel_coord_t coord_3_r;
    logic covered_3_r;
    logic last_3_r;

    always_ff @(posedge clk) begin
        if (!stall) begin
            az_3_r <= az_2_r;
            bz_3_r <= bz_2_r;
            cz_3_r <= cz_2_r;
            b0_3_r <= b0_2_c;
            b1_3_r <= b1_2_c;
            b2_3_r <= b2_2_c;
            coord_3_r <= coord_2_r;
            covered_3_r <= covered_2_c;
            last_3_r <= last_2_r;
        end
    end

    // Meaningful only for covered pixels.
    fixed_t depth_3_c;
    assign depth_3_c = bary_weight(b0_3_r, az_3_r, b1_3_r, bz_3_r, b2_3_r, cz_3_r);

    //////////////////////////////
    // Stage 4 output
    //////////////////////////////

    pixel_coord_t coord_4_r;
    fixed_t depth_4_r;
    logic covered_4_r;
    logic last_4_r;

    always_ff @(posedge clk) begin
        if (!stall) begin
            coord_4_r <= coord_3_r;
            depth_4_r <= depth_3_c;
            covered_4_r <= covered_3_r;
            last_4_r <= last_3_r;
        end
    end

    assign out_valid = valid_4_r;
    assign out_coord = coord_4_r;
    assign out_covered = covered_4_r;
    assign out_depth = depth_4_r;
    assign out_last = last_4_r;

    // No colour interpolation yet, so white.
    assign out_color = 12'hFFF;

    property p_out_hold;
        @(posedge clk) disable iff (!rstn)
        (out_valid && !out_ready) |=> out_valid && $stable(out_coord) && $stable(out_covered)
            && $stable(out_depth) && $stable(out_last);
    endproperty
    a_out_hold: assert property (p_out_hold)
        else $error("output changed while stalled");

endmodule

`default_nettype wire

// ==== raster_top.f ====
+incdir+common
common/raster_pkg.sv
source/triangle_setup.sv
source/pixel_sweep.sv
interpolator/triangle_interpolator.sv
source/raster_top.sv
tests/raster_checker.sv
tests/raster_tb.sv

// ==== source/pixel_sweep.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "raster_cfg.svh"

module pixel_sweep (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  setup_valid,
    output logic                  setup_ready,
    input  raster_pkg::triangle_t setup_tri,
    input  raster_pkg::fixed_t    setup_area_inv,
    output logic                  pix_valid,
    input  logic                  pix_ready,
    output raster_pkg::pixel_coord_t pix_coord,
    output logic                  pix_last,
    output raster_pkg::triangle_t pix_tri,
    output raster_pkg::fixed_t    pix_area_inv
);
    import raster_pkg::*;

    localparam int CW = `RASTER_COORD_BITS;
    localparam int X_HI = `RASTER_VIEWPORT_W - 1;
    localparam int Y_HI = `RASTER_VIEWPORT_H - 1;

    function automatic fixed_t min3(fixed_t a, fixed_t b, fixed_t c);
        fixed_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic fixed_t max3(fixed_t a, fixed_t b, fixed_t c);
        fixed_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // Integer part clamped into [0, hi].
    function automatic logic [CW-1:0] to_pixel(fixed_t v, int hi);
        int whole;
        whole = v >>> `RASTER_FRAC_BITS;
        if (whole < 0)
            whole = 0;
        else if (whole > hi)
            whole = hi;
        return CW'(whole);
    endfunction

    logic busy;
    logic setup_fire;
    logic pix_fire;
    logic [CW-1:0] box_x_min, box_x_max, box_y_min, box_y_max;
    logic [CW-1:0] x_min_r, x_max_r, y_max_r;
    logic [CW-1:0] x_cnt, y_cnt;
    triangle_t tri_r;
    fixed_t area_inv_r;

    assign box_x_min = to_pixel(min3(setup_tri.a.x, setup_tri.b.x, setup_tri.c.x), X_HI);
    assign box_x_max = to_pixel(max3(setup_tri.a.x, setup_tri.b.x, setup_tri.c.x), X_HI);
    assign box_y_min = to_pixel(min3(setup_tri.a.y, setup_tri.b.y, setup_tri.c.y), Y_HI);
    assign box_y_max = to_pixel(max3(setup_tri.a.y, setup_tri.b.y, setup_tri.c.y), Y_HI);

    assign setup_ready = !busy;
    assign setup_fire = setup_valid && setup_ready;
    assign pix_fire = pix_valid && pix_ready;

    always_ff @(posedge clk) begin
        if (setup_fire) begin
            x_min_r <= box_x_min;
            x_max_r <= box_x_max;
            y_max_r <= box_y_max;
            tri_r <= setup_tri;
            area_inv_r <= setup_area_inv;
        end
    end

    // Row-major walk that takes one pixel per handshake.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (setup_fire) begin
            busy <= 1'b1;
            x_cnt <= box_x_min;
            y_cnt <= box_y_min;
        end else if (pix_fire) begin
            if (pix_last) begin
                busy <= 1'b0;
            end else if (x_cnt == x_max_r) begin
                x_cnt <= x_min_r;
                y_cnt <= y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    assign pix_valid = busy;
    assign pix_coord.x = x_cnt;
    assign pix_coord.y = y_cnt;
    assign pix_last = (x_cnt == x_max_r) && (y_cnt == y_max_r);
    assign pix_tri = tri_r;
    assign pix_area_inv = area_inv_r;

    a_in_viewport: assert property (@(posedge clk) disable iff (!rstn)
        pix_valid |-> (pix_coord.x <= X_HI) && (pix_coord.y <= Y_HI))
        else $error("pixel (%0d, %0d) outside viewport", pix_coord.x, pix_coord.y);

endmodule

`default_nettype wire

// ==== source/raster_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               tri_valid,
    output logic               tri_ready,
    input  raster_pkg::fixed_t tri_ax,
    input  raster_pkg::fixed_t tri_ay,
    input  raster_pkg::fixed_t tri_az,
    input  raster_pkg::fixed_t tri_bx,
    input  raster_pkg::fixed_t tri_by,
    input  raster_pkg::fixed_t tri_bz,
    input  raster_pkg::fixed_t tri_cx,
    input  raster_pkg::fixed_t tri_cy,
    input  raster_pkg::fixed_t tri_cz,
    output logic               out_valid,
    input  logic               out_ready,
    output raster_pkg::pixel_coord_t out_coord,
    output logic               out_covered,
    output raster_pkg::fixed_t out_depth,
    output logic [11:0]        out_color,
    output logic               out_last
);
    import raster_pkg::*;

    triangle_t tri_in;

    // Setup to sweep.
    logic setup_valid;
    logic setup_ready;
    triangle_t setup_tri;
    fixed_t setup_area_inv;

    // Sweep to interpolator.
    logic pix_valid;
    logic pix_ready;
    pixel_coord_t pix_coord;
    logic pix_last;
    triangle_t pix_tri;
    fixed_t pix_area_inv;

    assign tri_in.a.x = tri_ax;
    assign tri_in.a.y = tri_ay;
    assign tri_in.a.z = tri_az;
    assign tri_in.b.x = tri_bx;
    assign tri_in.b.y = tri_by;
    assign tri_in.b.z = tri_bz;
    assign tri_in.c.x = tri_cx;
    assign tri_in.c.y = tri_cy;
    assign tri_in.c.z = tri_cz;

    triangle_setup setup_i (
        .clk            (clk),
        .rstn           (rstn),
        .tri_valid      (tri_valid),
        .tri_ready      (tri_ready),
        .tri_in         (tri_in),
        .setup_valid    (setup_valid),
        .setup_ready    (setup_ready),
        .setup_tri      (setup_tri),
        .setup_area_inv (setup_area_inv)
    );

    pixel_sweep sweep_i (
        .clk            (clk),
        .rstn           (rstn),
        .setup_valid    (setup_valid),
        .setup_ready    (setup_ready),
        .setup_tri      (setup_tri),
        .setup_area_inv (setup_area_inv),
        .pix_valid      (pix_valid),
        .pix_ready      (pix_ready),
        .pix_coord      (pix_coord),
        .pix_last       (pix_last),
        .pix_tri        (pix_tri),
        .pix_area_inv   (pix_area_inv)
    );

    triangle_interpolator interp_i (
        .clk          (clk),
        .rstn         (rstn),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .pix_coord    (pix_coord),
        .pix_last     (pix_last),
        .pix_tri      (pix_tri),
        .pix_area_inv (pix_area_inv),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_coord    (out_coord),
        .out_covered  (out_covered),
        .out_depth    (out_depth),
        .out_color    (out_color),
        .out_last     (out_last)
    );

endmodule

`default_nettype wire

// ==== source/triangle_setup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "raster_cfg.svh"

module triangle_setup (
    input  logic                clk,
    input  logic                rstn,
    input  logic                tri_valid,
    output logic                tri_ready,
    input  raster_pkg::triangle_t tri_in,
    output logic                setup_valid,
    input  logic                setup_ready,
    output raster_pkg::triangle_t setup_tri,
    output raster_pkg::fixed_t  setup_area_inv
);
    import raster_pkg::*;

    localparam int CNT_W = $clog2(`RASTER_DIV_BITS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_AREA,
        ST_DIVIDE,
        ST_HOLD
    } state_t;

    state_t state;
    logic [CNT_W-1:0] div_cnt;
    logic tri_fire;

    triangle_t tri_r;
    fixed_t area_c;
    fixed_t area_r;

    // Restoring divider state.
    logic [32:0] rem_r;
    logic [32:0] rem_shift;
    logic [`RASTER_DIV_BITS-1:0] quot_r;
    logic quot_bit;

    assign tri_ready = (state == ST_IDLE);
    assign tri_fire = tri_valid && tri_ready;
    assign setup_valid = (state == ST_HOLD);

    // Doubled signed area as edge a-b seen from vertex c.
    assign area_c = edge_eq(tri_r.a, tri_r.b, tri_r.c.x, tri_r.c.y);

    assign rem_shift = {rem_r[31:0], 1'b0};
    assign quot_bit = (rem_shift >= {1'b0, area_r});

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_IDLE;
            div_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (tri_fire)
                        state <= ST_AREA;
                end
                ST_AREA: begin
                    // Zero or negative area means degenerate or back-facing.
                    div_cnt <= '0;
                    state <= (area_c > 0) ? ST_DIVIDE : ST_IDLE;
                end
                ST_DIVIDE: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt == CNT_W'(`RASTER_DIV_BITS - 1))
                        state <= ST_HOLD;
                end
                ST_HOLD: begin
                    if (setup_ready)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Datapath
    //////////////////////////////

    // Dividend is 2^32, so the remainder starts at the bit above the quotient.
    // That bit only counts against a divisor of one.
    always_ff @(posedge clk) begin
        if (tri_fire)
            tri_r <= tri_in;
        if (state == ST_AREA) begin
            area_r <= area_c;
            rem_r <= (area_c == 32'sd1) ? 33'd0 : 33'd1;
            quot_r <= '0;
        end
        if (state == ST_DIVIDE) begin
            rem_r <= quot_bit ? (rem_shift - {1'b0, area_r}) : rem_shift;
            quot_r <= {quot_r[`RASTER_DIV_BITS-2:0], quot_bit};
        end
    end

    assign setup_tri = tri_r;
    assign setup_area_inv = fixed_t'(quot_r);

    // The first divide step must see the area registered by the area state.
    property p_div_positive;
        @(posedge clk) disable iff (!rstn)
        (state == ST_DIVIDE && div_cnt == '0) |-> (area_r > 0);
    endproperty
    a_div_positive: assert property (p_div_positive)
        else $error("divider started with non-positive area %h", area_r);

endmodule

`default_nettype wire

// ==== tests/raster_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "raster_cfg.svh"

module raster_checker (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     tri_valid,
    input  logic                     tri_ready,
    input  raster_pkg::fixed_t       tri_ax,
    input  raster_pkg::fixed_t       tri_ay,
    input  raster_pkg::fixed_t       tri_az,
    input  raster_pkg::fixed_t       tri_bx,
    input  raster_pkg::fixed_t       tri_by,
    input  raster_pkg::fixed_t       tri_bz,
    input  raster_pkg::fixed_t       tri_cx,
    input  raster_pkg::fixed_t       tri_cy,
    input  raster_pkg::fixed_t       tri_cz,
    input  logic                     out_valid,
    input  logic                     out_ready,
    input  raster_pkg::pixel_coord_t out_coord,
    input  logic                     out_covered,
    input  raster_pkg::fixed_t       out_depth,
    input  logic [11:0]              out_color,
    input  logic                     out_last,
    output int                       errors,
    output int                       tests_done,
    output int                       pixels_seen,
    output int                       pending
);
    import raster_pkg::*;

    localparam int STALL_LIMIT = 2000;

    // Expected output stream with one entry per pixel.
    pixel_coord_t exp_coord_q[$];
    logic exp_cov_q[$];
    fixed_t exp_depth_q[$];
    logic exp_last_q[$];
    int exp_test_q[$];

    int err_cnt = 0;
    int test_id = 0;
    int test_errs = 0;
    int done_cnt = 0;
    int pix_cnt = 0;
    int cur_pixels = 0;
    int cur_covered = 0;
    int idle_cycles = 0;

    // Integer pixel of a Q16.16 coordinate kept inside [0, hi].
    function automatic int clamp_pixel(fixed_t v, int hi);
        int p;
        p = v >>> `RASTER_FRAC_BITS;
        return (p < 0) ? 0 : ((p > hi) ? hi : p);
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp, int id);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h (test %0d)", name, got, exp, id);
            err_cnt++;
            test_errs++;
        end
    endtask

    task automatic expect_triangle(triangle_t t);
        fixed_t area;
        fixed_t inv;
        fixed_t px, py, f01, f12, f20;
        logic [63:0] quot;
        int x_lo, x_hi, y_lo, y_hi;
        test_id++;
        area = edge_eq(t.a, t.b, t.c.x, t.c.y);
        if (area <= 0) begin
            $display("test %0d: culled, area %h", test_id, area);
            done_cnt++;
            return;
        end
        quot = 64'h1_0000_0000 / {32'd0, area};
        inv = fixed_t'(quot[31:0]);
        x_lo = clamp_pixel((t.a.x < t.b.x) ? ((t.a.x < t.c.x) ? t.a.x : t.c.x)
            : ((t.b.x < t.c.x) ? t.b.x : t.c.x), `RASTER_VIEWPORT_W - 1);
        x_hi = clamp_pixel((t.a.x > t.b.x) ? ((t.a.x > t.c.x) ? t.a.x : t.c.x)
            : ((t.b.x > t.c.x) ? t.b.x : t.c.x), `RASTER_VIEWPORT_W - 1);
        y_lo = clamp_pixel((t.a.y < t.b.y) ? ((t.a.y < t.c.y) ? t.a.y : t.c.y)
            : ((t.b.y < t.c.y) ? t.b.y : t.c.y), `RASTER_VIEWPORT_H - 1);
        y_hi = clamp_pixel((t.a.y > t.b.y) ? ((t.a.y > t.c.y) ? t.a.y : t.c.y)
            : ((t.b.y > t.c.y) ? t.b.y : t.c.y), `RASTER_VIEWPORT_H - 1);
        for (int y = y_lo; y <= y_hi; y++) begin
            for (int x = x_lo; x <= x_hi; x++) begin
                px = fx_from_int(x);
                py = fx_from_int(y);
                f01 = edge_eq(t.a, t.b, px, py);
                f12 = edge_eq(t.b, t.c, px, py);
                f20 = edge_eq(t.c, t.a, px, py);
                exp_coord_q.push_back({8'(x), 8'(y)});
                exp_cov_q.push_back((f01 > 0) && (f12 > 0) && (f20 > 0));
                exp_depth_q.push_back(bary_weight(fx_mul(f01, inv), t.a.z,
                    fx_mul(f12, inv), t.b.z, fx_mul(f20, inv), t.c.z));
                exp_last_q.push_back((x == x_hi) && (y == y_hi));
                exp_test_q.push_back(test_id);
            end
        end
    endtask

    always @(posedge clk) begin
        pixel_coord_t e_coord;
        logic e_cov;
        fixed_t e_depth;
        logic e_last;
        int e_test;
        if (rstn && out_valid && out_ready) begin
            pix_cnt++;
            idle_cycles = 0;
            if (exp_coord_q.size() == 0) begin
                $display("unexpected output pixel (%0d, %0d) with nothing pending",
                    out_coord.x, out_coord.y);
                err_cnt++;
            end else begin
                e_coord = exp_coord_q.pop_front();
                e_cov = exp_cov_q.pop_front();
                e_depth = exp_depth_q.pop_front();
                e_last = exp_last_q.pop_front();
                e_test = exp_test_q.pop_front();
                cur_pixels++;
                cur_covered += e_cov;
                check_value("out_coord", 32'(out_coord), 32'(e_coord), e_test);
                check_value("out_covered", 32'(out_covered), 32'(e_cov), e_test);
                check_value("out_last", 32'(out_last), 32'(e_last), e_test);
                check_value("out_color", 32'(out_color), 32'h0fff, e_test);
                // Depth carries meaning only inside the triangle.
                if (e_cov)
                    check_value("out_depth", out_depth, e_depth, e_test);
                if (e_last) begin
                    $display("test %0d: %0d pixels, %0d covered, %0d errors",
                        e_test, cur_pixels, cur_covered, test_errs);
                    done_cnt++;
                    cur_pixels = 0;
                    cur_covered = 0;
                    test_errs = 0;
                end
            end
        end else if (exp_coord_q.size() != 0) begin
            idle_cycles++;
            if (idle_cycles == STALL_LIMIT) begin
                $display("no output pixel for %0d cycles while %0d pixels are outstanding",
                    STALL_LIMIT, exp_coord_q.size());
                err_cnt++;
            end
        end
        if (rstn && tri_valid && tri_ready)
            expect_triangle({tri_ax, tri_ay, tri_az, tri_bx, tri_by, tri_bz,
                tri_cx, tri_cy, tri_cz});
        errors <= err_cnt;
        tests_done <= done_cnt;
        pixels_seen <= pix_cnt;
        pending <= exp_coord_q.size();
    end

endmodule

`default_nettype wire

// ==== tests/raster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_tb;
    import raster_pkg::*;

    localparam int NUM_TRI = 24;
    localparam int WAIT_LIMIT = 5000;

    logic clk;
    logic rstn;
    logic tri_valid;
    logic tri_ready;
    fixed_t tri_ax, tri_ay, tri_az, tri_bx, tri_by, tri_bz, tri_cx, tri_cy, tri_cz;
    logic out_valid;
    logic out_ready;
    pixel_coord_t out_coord;
    logic out_covered;
    fixed_t out_depth;
    logic [11:0] out_color;
    logic out_last;

    int errors, tests_done, pixels_seen, pending;
    integer seed;
    logic stall_en;
    logic timed_out;

    // Columns per triangle are ax, ay, az, bx, by, bz, cx, cy and cz.
    fixed_t tri_list[NUM_TRI][9];

    raster_top dut_i (
        .clk(clk), .rstn(rstn), .tri_valid(tri_valid), .tri_ready(tri_ready),
        .tri_ax(tri_ax), .tri_ay(tri_ay), .tri_az(tri_az),
        .tri_bx(tri_bx), .tri_by(tri_by), .tri_bz(tri_bz),
        .tri_cx(tri_cx), .tri_cy(tri_cy), .tri_cz(tri_cz),
        .out_valid(out_valid), .out_ready(out_ready), .out_coord(out_coord),
        .out_covered(out_covered), .out_depth(out_depth), .out_color(out_color),
        .out_last(out_last)
    );

    raster_checker chk_i (
        .clk(clk), .rstn(rstn), .tri_valid(tri_valid), .tri_ready(tri_ready),
        .tri_ax(tri_ax), .tri_ay(tri_ay), .tri_az(tri_az),
        .tri_bx(tri_bx), .tri_by(tri_by), .tri_bz(tri_bz),
        .tri_cx(tri_cx), .tri_cy(tri_cy), .tri_cz(tri_cz),
        .out_valid(out_valid), .out_ready(out_ready), .out_coord(out_coord),
        .out_covered(out_covered), .out_depth(out_depth), .out_color(out_color),
        .out_last(out_last), .errors(errors), .tests_done(tests_done),
        .pixels_seen(pixels_seen), .pending(pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Output back-pressure holds ready low about 40 percent of the time when enabled.
    always @(posedge clk) begin
        if (stall_en)
            out_ready <= (($random(seed) & 32'h7fff_ffff) % 100) >= 40;
        else
            out_ready <= 1'b1;
    end

    function automatic int random_between(int lo, int hi);
        return lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    task automatic set_triangle(int idx, int ax, int ay, int bx, int by, int cx, int cy);
        tri_list[idx] = '{fx_from_int(ax), fx_from_int(ay), fx_from_int(10),
            fx_from_int(bx), fx_from_int(by), fx_from_int(50),
            fx_from_int(cx), fx_from_int(cy), fx_from_int(200)};
    endtask

    task automatic build_triangles();
        set_triangle(0, 1, 1, 14, 2, 3, 10);
        // Same triangle wound the other way, then collinear points.
        set_triangle(1, 1, 1, 3, 10, 14, 2);
        set_triangle(2, 2, 2, 6, 6, 10, 10);
        set_triangle(3, -4, -3, 30, -2, 2, 25);
        for (int i = 4; i < NUM_TRI; i++) begin
            for (int v = 0; v < 3; v++) begin
                tri_list[i][3*v] = fx_from_int(random_between(-3, 18));
                tri_list[i][3*v+1] = fx_from_int(random_between(-3, 14));
                tri_list[i][3*v+2] = $random(seed) & 32'h00ff_ffff;
            end
        end
    endtask

    task automatic send_triangle(int idx);
        int waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        {tri_ax, tri_ay, tri_az} <= {tri_list[idx][0], tri_list[idx][1], tri_list[idx][2]};
        {tri_bx, tri_by, tri_bz} <= {tri_list[idx][3], tri_list[idx][4], tri_list[idx][5]};
        {tri_cx, tri_cy, tri_cz} <= {tri_list[idx][6], tri_list[idx][7], tri_list[idx][8]};
        tri_valid <= 1'b1;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            if (tri_ready)
                accepted = 1'b1;
            else
                waited++;
        end
        tri_valid <= 1'b0;
        if (!accepted) begin
            $display("triangle %0d was not accepted within %0d cycles", idx, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_phase(logic stalls, string name);
        int waited;
        stall_en <= stalls;
        for (int i = 0; i < NUM_TRI && !timed_out; i++) begin
            repeat (i % 3) @(posedge clk);
            send_triangle(i);
        end
        repeat (2) @(posedge clk);
        waited = 0;
        while (pending != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("%0d pixels still missing after %0d cycles in the %s phase",
                pending, WAIT_LIMIT, name);
            timed_out = 1'b1;
        end
        // Room for any stray pixel to show up.
        repeat (20) @(posedge clk);
        stall_en <= 1'b0;
    endtask

    initial begin
        seed = 32'h204a_9fd0;
        timed_out = 1'b0;
        stall_en = 1'b0;
        rstn = 1'b0;
        tri_valid = 1'b0;
        out_ready = 1'b1;
        {tri_ax, tri_ay, tri_az, tri_bx, tri_by, tri_bz, tri_cx, tri_cy, tri_cz} = '0;
        build_triangles();
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        run_phase(1'b0, "unstalled");
        if (!timed_out)
            run_phase(1'b1, "stalled");
        $display("tests %0d, pixels %0d, errors %0d", tests_done, pixels_seen, errors);
        if (timed_out || errors != 0)
            $display("Regression failed");
        else
            $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
